// File: verilog/cu_bundles_pkg.sv
`default_nettype none

package cu_bundles_pkg;

// ------------------------------
// Sizes
// ------------------------------
// Bundles served by one compute unit
localparam int NUM_BUNDLES = 4;
// Bundle ID width, NUM_BUNDLES is a power of two
localparam int BUNDLE_ID_W = $clog2(NUM_BUNDLES);
localparam int ADDR_W      = 32;
localparam int DATA_W      = 32;

// ------------------------------
// FIFO thresholds
// ------------------------------
// Entries per packet FIFO, a power of two
localparam int FIFO_DEPTH  = 16;
localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
// Almost-full level, four entries of margin
localparam int PROG_THRESH = 12;

// ------------------------------
// Packets
// ------------------------------
typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
} mem_cmd_e;

// Request as a bundle issues it
typedef struct packed {
    mem_cmd_e          cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
} bundle_req_t;

// Request toward memory, ID on top
typedef struct packed {
    logic [BUNDLE_ID_W-1:0] id;
    bundle_req_t            req;
} mem_req_t;

// Response from memory, ID picks the bundle
typedef struct packed {
    logic [BUNDLE_ID_W-1:0] id;
    logic [DATA_W-1:0]      data;
} mem_resp_t;

endpackage : cu_bundles_pkg

`default_nettype wire

// File: verilog/packet_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module packet_fifo #(
    parameter type payload_t = logic
) (
    input  logic     ap_clk,
    input  logic     areset_cu_bundles,
    input  logic     push_i,
    input  payload_t din_i,
    input  logic     pop_i,
    output payload_t dout_o,
    output logic     empty_o,
    output logic     almost_full_o
);

import cu_bundles_pkg::*;

// Storage and pointers
payload_t              mem_q [FIFO_DEPTH];
logic [FIFO_PTR_W-1:0] wr_ptr;
logic [FIFO_PTR_W-1:0] rd_ptr;
logic [FIFO_PTR_W:0]   count;

logic full;
logic do_push;
logic do_pop;

// ------------------------------
// Flags
// ------------------------------
assign full          = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
assign empty_o       = (count == '0);
// Rises at PROG_THRESH entries
assign almost_full_o = (count >= (FIFO_PTR_W+1)'(PROG_THRESH));

// Overflow and underflow are dropped
assign do_push = push_i & ~full;
assign do_pop  = pop_i & ~empty_o;

// Show-ahead, head visible with no read latency
assign dout_o = mem_q[rd_ptr];

// ------------------------------
// Pointers and fill level
// ------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_bundles) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end
    else begin
        // Pointers wrap on their own at FIFO_DEPTH
        if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// Payload write
always_ff @(posedge ap_clk) begin
    if (do_push) begin
        mem_q[wr_ptr] <= din_i;
    end
end

endmodule : packet_fifo

`default_nettype wire

// File: verilog/request_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module request_arbiter (
    input  logic                                   ap_clk,
    input  logic                                   areset_cu_bundles,
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_req_valid_i,
    input  cu_bundles_pkg::bundle_req_t            bundle_req_i [cu_bundles_pkg::NUM_BUNDLES],
    output logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_req_ready_o,
    input  logic                                   mem_req_ready_i,
    output logic                                   mem_req_valid_o,
    output cu_bundles_pkg::mem_req_t               mem_req_o,
    output logic                                   idle_o
);

import cu_bundles_pkg::*;

// Last granted bundle
logic [BUNDLE_ID_W-1:0] rr_ptr;

// Current pick
logic [BUNDLE_ID_W-1:0] pick_id;
logic                   pick_found;
logic                   grant_valid;

// Output FIFO side
mem_req_t push_pkt;
logic     fifo_empty;
logic     fifo_almost_full;

// ------------------------------
// Round-robin pick
// ------------------------------
// Search starts one past the last grant and wraps
always_comb begin
    logic [BUNDLE_ID_W-1:0] cand;
    pick_found = 1'b0;
    pick_id    = rr_ptr;
    for (int k = 1; k <= NUM_BUNDLES; k++) begin
        cand = rr_ptr + BUNDLE_ID_W'(k);
        if (!pick_found && bundle_req_valid_i[cand]) begin
            pick_found = 1'b1;
            pick_id    = cand;
        end
    end
end

// No grant while the output FIFO is almost full
assign grant_valid = pick_found & ~fifo_almost_full;

// One-hot ready toward the granted bundle
always_comb begin
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        bundle_req_ready_o[i] = grant_valid && (pick_id == BUNDLE_ID_W'(i));
    end
end

// Pointer moves only on a real grant
always_ff @(posedge ap_clk) begin
    if (areset_cu_bundles) begin
        // Bundle 0 first out of reset
        rr_ptr <= BUNDLE_ID_W'(NUM_BUNDLES - 1);
    end
    else if (grant_valid) begin
        rr_ptr <= pick_id;
    end
end

// ------------------------------
// Output FIFO toward memory
// ------------------------------
// Stamp the bundle index as the ID
assign push_pkt = '{id: pick_id, req: bundle_req_i[pick_id]};

packet_fifo #(
    .payload_t(mem_req_t)
) inst_fifo_request_out (
    .ap_clk           (ap_clk           ),
    .areset_cu_bundles(areset_cu_bundles),
    .push_i           (grant_valid      ),
    .din_i            (push_pkt         ),
    .pop_i            (mem_req_ready_i  ),
    .dout_o           (mem_req_o        ),
    .empty_o          (fifo_empty       ),
    .almost_full_o    (fifo_almost_full )
);

// Head is valid whenever something is queued
assign mem_req_valid_o = ~fifo_empty;

// A grant in flight counts as traffic
assign idle_o = fifo_empty & ~grant_valid;

endmodule : request_arbiter

`default_nettype wire

// File: verilog/response_router.sv
`default_nettype none
`timescale 1ns/10ps

module response_router (
    input  logic                                   ap_clk,
    input  logic                                   areset_cu_bundles,
    input  logic                                   mem_resp_valid_i,
    input  cu_bundles_pkg::mem_resp_t              mem_resp_i,
    output logic                                   mem_resp_full_o,
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_resp_full_i,
    output logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_resp_valid_o,
    output cu_bundles_pkg::mem_resp_t              bundle_resp_o [cu_bundles_pkg::NUM_BUNDLES],
    output logic                                   idle_o
);

import cu_bundles_pkg::*;

// Head of the input FIFO
mem_resp_t head;
logic      fifo_empty;
logic      head_pop;

// Decoded target of the head
logic [NUM_BUNDLES-1:0] head_sel;

// ------------------------------
// Input FIFO from memory
// ------------------------------
packet_fifo #(
    .payload_t(mem_resp_t)
) inst_fifo_response_in (
    .ap_clk           (ap_clk           ),
    .areset_cu_bundles(areset_cu_bundles),
    .push_i           (mem_resp_valid_i ),
    .din_i            (mem_resp_i       ),
    .pop_i            (head_pop         ),
    .dout_o           (head             ),
    .empty_o          (fifo_empty       ),
    .almost_full_o    (mem_resp_full_o  )
);

// ------------------------------
// Route by ID
// ------------------------------
always_comb begin
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        head_sel[i] = (head.id == BUNDLE_ID_W'(i));
    end
end

// Full target holds the head, and everything behind it
assign head_pop = ~fifo_empty & ~bundle_resp_full_i[head.id];

// One-cycle valid pulse to the target only
always_ff @(posedge ap_clk) begin
    if (areset_cu_bundles) begin
        bundle_resp_valid_o <= '0;
    end
    else if (head_pop) begin
        bundle_resp_valid_o <= head_sel;
    end
    else begin
        bundle_resp_valid_o <= '0;
    end
end

// Per-lane payload, loaded on its own delivery
always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        if (head_pop && head_sel[i]) begin
            bundle_resp_o[i] <= head;
        end
    end
end

// Idle once queued, arriving and delivered traffic is gone
assign idle_o = fifo_empty & ~mem_resp_valid_i & ~(|bundle_resp_valid_o);

endmodule : response_router

`default_nettype wire

// File: verilog/cu_bundles_status.sv
`default_nettype none
`timescale 1ns/10ps

module cu_bundles_status (
    input  logic                                   ap_clk,
    input  logic                                   areset_cu_bundles,
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_done_i,
    input  logic                                   req_idle_i,
    input  logic                                   resp_idle_i,
    output logic                                   done_o
);

// Every bundle reports done
logic all_done;
// Nothing queued or in flight on either path
logic paths_idle;

assign all_done   = &bundle_done_i;
assign paths_idle = req_idle_i & resp_idle_i;

// ------------------------------
// Registered done
// ------------------------------
// Low through reset, then one cycle behind its inputs
always_ff @(posedge ap_clk) begin
    if (areset_cu_bundles) begin
        done_o <= 1'b0;
    end
    else begin
        // Any done bit dropping or new traffic clears it
        done_o <= all_done & paths_idle;
    end
end

endmodule : cu_bundles_status

`default_nettype wire

// File: verilog/cu_bundles.sv
`default_nettype none
`timescale 1ns/10ps

module cu_bundles (
    input  logic                                   ap_clk,
    input  logic                                   areset_cu_bundles,
    // Bundle requests
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_req_valid_i,
    input  cu_bundles_pkg::bundle_req_t            bundle_req_i [cu_bundles_pkg::NUM_BUNDLES],
    output logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_req_ready_o,
    // Memory requests
    input  logic                                   mem_req_ready_i,
    output logic                                   mem_req_valid_o,
    output cu_bundles_pkg::mem_req_t               mem_req_o,
    // Memory responses
    input  logic                                   mem_resp_valid_i,
    input  cu_bundles_pkg::mem_resp_t              mem_resp_i,
    output logic                                   mem_resp_full_o,
    // Bundle responses
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_resp_full_i,
    output logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_resp_valid_o,
    output cu_bundles_pkg::mem_resp_t              bundle_resp_o [cu_bundles_pkg::NUM_BUNDLES],
    // Status
    input  logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_done_i,
    output logic                                   done_o
);

// Retimed reset shared by all three parts
logic areset_retimed;

// Path idle flags into status
logic req_idle;
logic resp_idle;

// ------------------------------
// Reset retime
// ------------------------------
always_ff @(posedge ap_clk) begin
    areset_retimed <= areset_cu_bundles;
end

// Request path, bundles to memory
request_arbiter inst_request_arbiter (
    .ap_clk            (ap_clk            ),
    .areset_cu_bundles (areset_retimed    ),
    .bundle_req_valid_i(bundle_req_valid_i),
    .bundle_req_i      (bundle_req_i      ),
    .bundle_req_ready_o(bundle_req_ready_o),
    .mem_req_ready_i   (mem_req_ready_i   ),
    .mem_req_valid_o   (mem_req_valid_o   ),
    .mem_req_o         (mem_req_o         ),
    .idle_o            (req_idle          )
);

// Response path, memory to bundles
response_router inst_response_router (
    .ap_clk             (ap_clk             ),
    .areset_cu_bundles  (areset_retimed     ),
    .mem_resp_valid_i   (mem_resp_valid_i   ),
    .mem_resp_i         (mem_resp_i         ),
    .mem_resp_full_o    (mem_resp_full_o    ),
    .bundle_resp_full_i (bundle_resp_full_i ),
    .bundle_resp_valid_o(bundle_resp_valid_o),
    .bundle_resp_o      (bundle_resp_o      ),
    .idle_o             (resp_idle          )
);

// ------------------------------
// Done
// ------------------------------
cu_bundles_status inst_cu_bundles_status (
    .ap_clk           (ap_clk        ),
    .areset_cu_bundles(areset_retimed),
    .bundle_done_i    (bundle_done_i ),
    .req_idle_i       (req_idle      ),
    .resp_idle_i      (resp_idle     ),
    .done_o           (done_o        )
);

endmodule : cu_bundles

`default_nettype wire

// File: test/cu_bundles_checker.sv
`default_nettype none
`timescale 1ns/10ps

module cu_bundles_checker (
    input logic                                   ap_clk,
    input logic                                   areset_i,
    input logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_req_ready_i,
    input logic [cu_bundles_pkg::NUM_BUNDLES-1:0] bundle_resp_valid_i,
    input logic                                   mem_req_valid_i,
    input logic                                   mem_resp_full_i,
    input logic                                   done_i
);

// At most one bundle granted per cycle
grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_i)
    $onehot0(bundle_req_ready_i))
    else $error("bundle_req_ready_o grants more than one bundle");

// Outputs quiet right after reset
reset_quiet: assert property (@(posedge ap_clk)
    areset_i |=> !mem_req_valid_i && (bundle_resp_valid_i == '0) && !mem_resp_full_i && !done_i)
    else $error("Output high in the cycle after reset");

// Done only with the request path empty
done_idle: assert property (@(posedge ap_clk) disable iff (areset_i)
    !(done_i && mem_req_valid_i))
    else $error("done_o high while mem_req_valid_o is high");

endmodule : cu_bundles_checker

// Watches the retimed reset inside the top
bind cu_bundles cu_bundles_checker inst_checker (
    .ap_clk             (ap_clk             ),
    .areset_i           (areset_retimed     ),
    .bundle_req_ready_i (bundle_req_ready_o ),
    .bundle_resp_valid_i(bundle_resp_valid_o),
    .mem_req_valid_i    (mem_req_valid_o    ),
    .mem_resp_full_i    (mem_resp_full_o    ),
    .done_i             (done_o             )
);

`default_nettype wire

// File: test/cu_bundles_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cu_bundles_tb;

import cu_bundles_pkg::*;

// ------------------------------
// Stimulus table
// ------------------------------
typedef struct packed {
    logic [NUM_BUNDLES-1:0] req_en;
    logic                   mem_ready;
    logic                   resp_en;
    logic [NUM_BUNDLES-1:0] full;
    logic [NUM_BUNDLES-1:0] done;
    int                     cycles;
} step_t;

localparam int          NUM_STEPS       = 14;
localparam int          WATCHDOG_CYCLES = NUM_STEPS * 40 + 200;
localparam logic [31:0] RNG_SEED        = 32'h1f8a_5a95;

// Request enables, memory ready, response push, full mask, done mask, cycles
step_t steps [NUM_STEPS] = '{
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 5},
    '{4'b0001, 1'b1, 1'b0, 4'b0000, 4'b0000, 20},
    '{4'b1111, 1'b1, 1'b0, 4'b0000, 4'b0000, 30},
    // Memory stalled so grants stop at the threshold
    '{4'b1111, 1'b0, 1'b0, 4'b0000, 4'b0000, 25},
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 25},
    // Responses flow before bundle 2 blocks the head
    '{4'b0000, 1'b1, 1'b1, 4'b0000, 4'b0000, 30},
    '{4'b0000, 1'b1, 1'b1, 4'b0100, 4'b0000, 20},
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b0000, 25},
    // Done rises then falls on a done bit and again on traffic
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b1111, 10},
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b1011, 6},
    '{4'b0010, 1'b1, 1'b0, 4'b0000, 4'b1111, 6},
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b1111, 15},
    // Both paths busy at once
    '{4'b1111, 1'b1, 1'b1, 4'b1001, 4'b1111, 30},
    '{4'b0000, 1'b1, 1'b0, 4'b0000, 4'b1111, 30}
};

// DUT inputs
logic                   ap_clk;
logic                   areset_cu_bundles = 1'b1;
logic [NUM_BUNDLES-1:0] bundle_req_valid  = '0;
bundle_req_t            bundle_req [NUM_BUNDLES] = '{default: '0};
logic                   mem_req_ready     = 1'b0;
logic                   mem_resp_valid    = 1'b0;
mem_resp_t              mem_resp          = '0;
logic [NUM_BUNDLES-1:0] bundle_resp_full  = '0;
logic [NUM_BUNDLES-1:0] bundle_done       = '0;
// DUT outputs
logic [NUM_BUNDLES-1:0] bundle_req_ready;
logic                   mem_req_valid;
mem_req_t               mem_req;
logic                   mem_resp_full;
logic [NUM_BUNDLES-1:0] bundle_resp_valid;
mem_resp_t              bundle_resp [NUM_BUNDLES];
logic                   done;

// Scoreboard queues mirror the two FIFOs
mem_req_t               req_q [$];
mem_resp_t              resp_q [$];
logic [BUNDLE_ID_W-1:0] last_grant;
logic [NUM_BUNDLES-1:0] resp_valid_exp;
mem_resp_t              resp_exp;
logic                   done_exp;
int                     req_errors;
int                     resp_errors;
int                     flag_errors;
int                     other_errors;

cu_bundles cu_bundles_inst (
    .ap_clk             (ap_clk           ),
    .areset_cu_bundles  (areset_cu_bundles),
    .bundle_req_valid_i (bundle_req_valid ),
    .bundle_req_i       (bundle_req       ),
    .bundle_req_ready_o (bundle_req_ready ),
    .mem_req_ready_i    (mem_req_ready    ),
    .mem_req_valid_o    (mem_req_valid    ),
    .mem_req_o          (mem_req          ),
    .mem_resp_valid_i   (mem_resp_valid   ),
    .mem_resp_i         (mem_resp         ),
    .mem_resp_full_o    (mem_resp_full    ),
    .bundle_resp_full_i (bundle_resp_full ),
    .bundle_resp_valid_o(bundle_resp_valid),
    .bundle_resp_o      (bundle_resp      ),
    .bundle_done_i      (bundle_done      ),
    .done_o             (done             )
);

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (exp !== act) begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        req_errors++;
    end
endtask

task automatic check_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
    if (exp !== act) begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        resp_errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        flag_errors++;
    end
endtask

// Check one cycle at the falling edge and drive the next inputs
task automatic run_cycle(input step_t st);
    logic [NUM_BUNDLES-1:0] exp_ready;
    logic [NUM_BUNDLES-1:0] accepted;
    logic [BUNDLE_ID_W-1:0] cand;
    mem_req_t               exp_req;
    logic                   resp_stop;
    @(negedge ap_clk);
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        check_bit($sformatf("bundle_resp_valid_o[%0d]", i), resp_valid_exp[i],
                  bundle_resp_valid[i]);
        if (resp_valid_exp[i]) begin
            check_resp($sformatf("bundle_resp_o[%0d]", i), resp_exp, bundle_resp[i]);
        end
    end
    check_bit("done_o", done_exp, done);
    check_bit("mem_resp_full_o", resp_q.size() >= PROG_THRESH, mem_resp_full);
    check_bit("mem_req_valid_o", req_q.size() != 0, mem_req_valid);
    resp_stop = mem_resp_full;
    // Round-robin pick with no grant while the output FIFO is almost full
    exp_ready = '0;
    if (req_q.size() < PROG_THRESH) begin
        for (int k = 1; k <= NUM_BUNDLES; k++) begin
            cand = last_grant + BUNDLE_ID_W'(k);
            if (exp_ready == '0 && bundle_req_valid[cand]) begin
                exp_ready[cand] = 1'b1;
            end
        end
    end
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        check_bit($sformatf("bundle_req_ready_o[%0d]", i), exp_ready[i], bundle_req_ready[i]);
    end
    // Done one cycle behind all flags and empty paths
    done_exp = (&bundle_done) && (req_q.size() == 0) && (exp_ready == '0)
               && (resp_q.size() == 0) && !mem_resp_valid && (resp_valid_exp == '0);
    // Head leaves toward memory
    if (mem_req_ready && req_q.size() != 0) begin
        check_mem_req("mem_req_o", req_q.pop_front(), mem_req);
    end
    accepted = bundle_req_valid & bundle_req_ready;
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        if (accepted[i]) begin
            exp_req.id  = BUNDLE_ID_W'(i);
            exp_req.req = bundle_req[i];
            req_q.push_back(exp_req);
            last_grant = BUNDLE_ID_W'(i);
        end
    end
    // Head goes out unless its bundle is full
    resp_valid_exp = '0;
    if (resp_q.size() != 0 && !bundle_resp_full[resp_q[0].id]) begin
        resp_exp = resp_q.pop_front();
        resp_valid_exp[resp_exp.id] = 1'b1;
    end
    if (mem_resp_valid) begin
        resp_q.push_back(mem_resp);
    end

    @(posedge ap_clk);
    // Requests held until accepted
    for (int i = 0; i < NUM_BUNDLES; i++) begin
        if (accepted[i] || !bundle_req_valid[i]) begin
            bundle_req_valid[i] <= st.req_en[i];
            bundle_req[i].cmd   <= ($urandom_range(1) == 1) ? CMD_WRITE : CMD_READ;
            bundle_req[i].addr  <= $urandom();
            bundle_req[i].data  <= $urandom();
        end
    end
    mem_req_ready    <= st.mem_ready;
    bundle_resp_full <= st.full;
    bundle_done      <= st.done;
    // Memory stops sending on almost-full
    mem_resp_valid   <= st.resp_en && !resp_stop;
    mem_resp.id      <= BUNDLE_ID_W'($urandom_range(NUM_BUNDLES - 1));
    mem_resp.data    <= $urandom();
endtask

// ------------------------------
// Clock, reset and watchdog
// ------------------------------
initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
end

initial begin
    repeat (10) @(posedge ap_clk);
    areset_cu_bundles <= 1'b0;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
end

// ------------------------------
// Stimulus
// ------------------------------
initial begin
    void'($urandom(RNG_SEED));
    last_grant     = BUNDLE_ID_W'(NUM_BUNDLES - 1);
    resp_valid_exp = '0;
    resp_exp       = '0;
    done_exp       = 1'b0;
    req_errors     = 0;
    resp_errors    = 0;
    flag_errors    = 0;
    other_errors   = 0;
    wait (areset_cu_bundles == 1'b0);
    repeat (4) @(negedge ap_clk);
    // Outputs after reset
    check_bit("mem_req_valid_o", 1'b0, mem_req_valid);
    check_bit("bundle_req_ready_o", 1'b0, |bundle_req_ready);
    check_bit("bundle_resp_valid_o", 1'b0, |bundle_resp_valid);
    check_bit("mem_resp_full_o", 1'b0, mem_resp_full);
    check_bit("done_o", 1'b0, done);
    for (int s = 0; s < NUM_STEPS; s++) begin
        for (int c = 0; c < steps[s].cycles; c++) begin
            run_cycle(steps[s]);
        end
    end
    if (req_q.size() != 0 || resp_q.size() != 0) begin
        $display("Traffic left at the end: %0d requests, %0d responses",
                 req_q.size(), resp_q.size());
        other_errors++;
    end
    $display("Error counts: mem_req %0d, resp %0d, flags %0d, other %0d",
             req_errors, resp_errors, flag_errors, other_errors);
    if (req_errors + resp_errors + flag_errors + other_errors == 0) begin
        $display("NO ERRORS");
    end
    else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule : cu_bundles_tb

`default_nettype wire

// File: cu_bundles.f
verilog/cu_bundles_pkg.sv
verilog/packet_fifo.sv
verilog/request_arbiter.sv
verilog/response_router.sv
verilog/cu_bundles_status.sv
verilog/cu_bundles.sv
test/cu_bundles_checker.sv
test/cu_bundles_tb.sv

// File: Makefile
# Verilator build and run of the cu_bundles testbench
TOP := cu_bundles_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

obj_dir/V$(TOP): cu_bundles.f verilog/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cu_bundles.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cu_bundles.f

clean:
	rm -rf obj_dir
